// ==== Bender.yml ====
package:
  name: tomasulo

sources:
  - common/tomasulo_pkg.sv
  - design/issue_stage.sv
  - rs/rs_alu.sv
  - rs/rs_ls.sv
  - exec/alu_unit.sv
  - exec/ls_unit.sv
  - design/cdb_arbiter.sv
  - design/tomasulo_core.sv
  - target: simulation
    files:
      - sim/tb_tomasulo.sv

// ==== common/tomasulo_pkg.sv ====
package tomasulo_pkg;

    localparam int num_regs  = 8;
    localparam int mem_words = 16;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  regaddr_t;
    typedef logic [1:0]  tag_t;
    typedef logic [3:0]  memaddr_t;

    // One producer id per reservation station
    localparam tag_t tag_none = 2'd0;
    localparam tag_t tag_alu0 = 2'd1;
    localparam tag_t tag_alu1 = 2'd2;
    localparam tag_t tag_ls   = 2'd3;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_addi,
        op_load,
        op_store
    } op_e;

    typedef struct packed {
        op_e      op;
        regaddr_t dest;
        regaddr_t src1;
        regaddr_t src2;
        word_t    imm;
    } issue_t;

    typedef struct packed {
        op_e   op;
        tag_t  tag1;      // Pending producer of val1
        tag_t  tag2;      // Pending producer of val2
        word_t val1;      // ALU operand a, or load/store base
        word_t val2;      // ALU operand b, or store data
        word_t imm;
        tag_t  dest_tag;  // Station that owns the result
    } rs_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } cdb_t;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_mem,
        st_wait_grant
    } ls_state_e;

endpackage

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/10ps

module cdb_arbiter import tomasulo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cdb_t       req [3],
    output logic [2:0] grant,
    output cdb_t       cdb
);

    logic [1:0] ptr;  // Index with the highest priority
    logic [1:0] win;
    logic [2:0] req_valid;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            req_valid[i] = req[i].valid;
        end
    end

    always_comb begin
        logic [1:0] idx;
        logic       found;
        grant = 3'b000;
        win   = 2'd0;
        found = 1'b0;
        for (int k = 0; k < 3; k++) begin
            idx = 2'((int'(ptr) + k) % 3);
            if (!found && req_valid[idx]) begin
                found = 1'b1;
                win   = idx;
            end
        end
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    assign cdb = (|grant) ? req[win] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= 2'd0;
        end else if (|grant) begin
            ptr <= (win == 2'd2) ? 2'd0 : win + 2'd1;  // Winner drops to lowest priority
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("cdb_arbiter: more than one grant");

    assert property (@(posedge clk) disable iff (rst) (grant & req_valid) == grant)
        else $error("cdb_arbiter: grant to an idle requester");

    for (genvar i = 0; i < 3; i++) begin : g_hold
        assert property (@(posedge clk) disable iff (rst)
            req_valid[i] && !grant[i] |=> req_valid[i])
            else $error("cdb_arbiter: request %0d withdrawn before grant", i);
    end

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage import tomasulo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       issue_ready,
    input  logic [2:0] rs_busy,
    output logic [2:0] alloc,
    output rs_entry_t  alloc_entry,
    input  cdb_t       cdb,
    input  regaddr_t   rd_addr,
    output word_t      rd_data,
    output tag_t       rd_tag
);

    word_t      regs [num_regs];
    tag_t       tags [num_regs];
    logic       is_ls;
    logic       uses_src2;
    logic [2:0] free_sel;
    tag_t       new_tag;
    logic       fire;

    assign is_ls     = issue.op inside {op_load, op_store};
    assign uses_src2 = !(issue.op inside {op_addi, op_load});

    // Station choice with alu0 before alu1
    always_comb begin
        free_sel = 3'b000;
        new_tag  = tag_none;
        if (is_ls) begin
            if (!rs_busy[2]) begin
                free_sel = 3'b100;
                new_tag  = tag_ls;
            end
        end else if (!rs_busy[0]) begin
            free_sel = 3'b001;
            new_tag  = tag_alu0;
        end else if (!rs_busy[1]) begin
            free_sel = 3'b010;
            new_tag  = tag_alu1;
        end
    end

    assign issue_ready = |free_sel;
    assign fire        = issue_valid && issue_ready;
    assign alloc       = fire ? free_sel : 3'b000;

    // Source operands with a same cycle bypass from the CDB
    always_comb begin
        tag_t t1;
        tag_t t2;
        t1 = tags[issue.src1];
        t2 = tags[issue.src2];
        alloc_entry.op       = issue.op;
        alloc_entry.imm      = issue.imm;
        alloc_entry.dest_tag = new_tag;
        alloc_entry.tag1     = t1;
        alloc_entry.val1     = regs[issue.src1];
        alloc_entry.tag2     = t2;
        alloc_entry.val2     = regs[issue.src2];
        if (t1 != tag_none && cdb.valid && cdb.tag == t1) begin
            alloc_entry.tag1 = tag_none;
            alloc_entry.val1 = cdb.data;
        end
        if (t2 != tag_none && cdb.valid && cdb.tag == t2) begin
            alloc_entry.tag2 = tag_none;
            alloc_entry.val2 = cdb.data;
        end
        if (!uses_src2) begin
            alloc_entry.tag2 = tag_none;
            alloc_entry.val2 = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= tag_none;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (cdb.valid && tags[i] != tag_none && tags[i] == cdb.tag) begin
                    regs[i] <= cdb.data;
                    tags[i] <= tag_none;
                end
            end
            if (fire && issue.op != op_store) begin
                tags[issue.dest] <= new_tag;  // Later assignment beats the CDB clear
            end
        end
    end

    assign rd_data = regs[rd_addr];
    assign rd_tag  = tags[rd_addr];

endmodule

// ==== design/tomasulo_core.sv ====
`timescale 1ns/10ps

module tomasulo_core import tomasulo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  issue_t   issue,
    output logic     issue_ready,
    input  regaddr_t rd_addr,
    output word_t    rd_data,
    output tag_t     rd_tag,
    output cdb_t     cdb
);

    // Index 0 and 1 are the ALU paths, 2 is load/store
    logic [2:0] rs_busy;
    logic [2:0] alloc;
    logic [2:0] grant;
    logic [2:0] exec_valid;
    logic [2:0] exec_ready;
    rs_entry_t  alloc_entry;
    rs_entry_t  exec_entry [3];
    cdb_t       req [3];
    logic       store_done;

    issue_stage issue_stage_i (
        .clk, .rst, .issue_valid, .issue, .issue_ready,
        .rs_busy, .alloc, .alloc_entry, .cdb,
        .rd_addr, .rd_data, .rd_tag
    );

    for (genvar i = 0; i < 2; i++) begin : g_alu
        rs_alu rs_alu_i (
            .clk, .rst, .alloc(alloc[i]), .alloc_entry, .cdb, .cdb_grant(grant[i]),
            .busy(rs_busy[i]), .exec_valid(exec_valid[i]),
            .exec_entry(exec_entry[i]), .exec_ready(exec_ready[i])
        );

        alu_unit #(.own_tag(tag_t'(i + 1))) alu_unit_i (
            .clk, .rst, .exec_valid(exec_valid[i]), .exec_entry(exec_entry[i]),
            .exec_ready(exec_ready[i]), .req(req[i]), .grant(grant[i])
        );
    end

    rs_ls rs_ls_i (
        .clk, .rst, .alloc(alloc[2]), .alloc_entry, .cdb, .cdb_grant(grant[2]),
        .store_done, .busy(rs_busy[2]), .exec_valid(exec_valid[2]),
        .exec_entry(exec_entry[2]), .exec_ready(exec_ready[2])
    );

    ls_unit ls_unit_i (
        .clk, .rst, .exec_valid(exec_valid[2]), .exec_entry(exec_entry[2]),
        .exec_ready(exec_ready[2]), .req(req[2]), .grant(grant[2]), .store_done
    );

    cdb_arbiter cdb_arbiter_i (
        .clk, .rst, .req, .grant, .cdb
    );

endmodule

// ==== exec/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit import tomasulo_pkg::*; #(
    parameter tag_t own_tag = tag_alu0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      exec_valid,
    input  rs_entry_t exec_entry,
    output logic      exec_ready,
    output cdb_t      req,
    input  logic      grant
);

    logic  pending;
    word_t result;
    word_t alu_out;

    always_comb begin
        case (exec_entry.op)
            op_sub:  alu_out = exec_entry.val1 - exec_entry.val2;
            op_and:  alu_out = exec_entry.val1 & exec_entry.val2;
            op_xor:  alu_out = exec_entry.val1 ^ exec_entry.val2;
            op_addi: alu_out = exec_entry.val1 + exec_entry.imm;
            default: alu_out = exec_entry.val1 + exec_entry.val2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (exec_valid && exec_ready) begin
            pending <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid && exec_ready) begin
            result <= alu_out;
        end
    end

    assign exec_ready = !pending;
    assign req        = '{valid: pending, tag: own_tag, data: result};

endmodule

// ==== exec/ls_unit.sv ====
`timescale 1ns/10ps

module ls_unit import tomasulo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      exec_valid,
    input  rs_entry_t exec_entry,
    output logic      exec_ready,
    output cdb_t      req,
    input  logic      grant,
    output logic      store_done
);

    ls_state_e state;
    rs_entry_t ent;
    memaddr_t  addr;
    word_t     load_data;
    word_t     mem [mem_words];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:       if (exec_valid) state <= st_addr;
                st_addr:       state <= st_mem;
                st_mem:        state <= (ent.op == op_store) ? st_idle : st_wait_grant;
                st_wait_grant: if (grant) state <= st_idle;
                default:       state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && exec_valid) begin
            ent <= exec_entry;
        end
        if (state == st_addr) begin
            addr <= ent.val1[3:0] + ent.imm[3:0];  // Word address wraps in 16
        end
        if (state == st_mem && ent.op == op_load) begin
            load_data <= mem[addr];
        end
    end

    // Memory starts cleared so loads of unwritten words return zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (store_done) begin
            mem[addr] <= ent.val2;
        end
    end

    assign exec_ready = state == st_idle;
    assign store_done = state == st_mem && ent.op == op_store;
    assign req        = '{valid: state == st_wait_grant, tag: tag_ls, data: load_data};

endmodule

// ==== filelist.f ====
common/tomasulo_pkg.sv
design/issue_stage.sv
rs/rs_alu.sv
rs/rs_ls.sv
exec/alu_unit.sv
exec/ls_unit.sv
design/cdb_arbiter.sv
design/tomasulo_core.sv
sim/tb_tomasulo.sv

// ==== rs/rs_alu.sv ====
`timescale 1ns/10ps

module rs_alu import tomasulo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  rs_entry_t alloc_entry,
    input  cdb_t      cdb,
    input  logic      cdb_grant,
    output logic      busy,
    output logic      exec_valid,
    output rs_entry_t exec_entry,
    input  logic      exec_ready
);

    rs_entry_t ent;
    logic      issued;  // Entry already handed to the unit

    assign exec_valid = busy && !issued && ent.tag1 == tag_none && ent.tag2 == tag_none;
    assign exec_entry = ent;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            issued <= 1'b0;
        end else if (alloc) begin
            busy   <= 1'b1;
            issued <= 1'b0;
        end else begin
            if (exec_valid && exec_ready) begin
                issued <= 1'b1;
            end
            if (cdb_grant) begin
                busy <= 1'b0;  // Result is on the bus this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent <= alloc_entry;
        end else if (busy && cdb.valid) begin
            if (ent.tag1 != tag_none && ent.tag1 == cdb.tag) begin
                ent.tag1 <= tag_none;
                ent.val1 <= cdb.data;
            end
            if (ent.tag2 != tag_none && ent.tag2 == cdb.tag) begin
                ent.tag2 <= tag_none;
                ent.val2 <= cdb.data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) alloc |-> !busy)
        else $error("rs_alu: allocated while busy");

    assert property (@(posedge clk) disable iff (rst) cdb_grant |-> busy && issued)
        else $error("rs_alu: grant without an executing entry");

endmodule

// ==== rs/rs_ls.sv ====
`timescale 1ns/10ps

module rs_ls import tomasulo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  rs_entry_t alloc_entry,
    input  cdb_t      cdb,
    input  logic      cdb_grant,
    input  logic      store_done,
    output logic      busy,
    output logic      exec_valid,
    output rs_entry_t exec_entry,
    input  logic      exec_ready
);

    rs_entry_t ent;
    logic      issued;
    logic      done;

    // Loads leave on the CDB grant, stores once memory is written
    assign done = cdb_grant || store_done;

    assign exec_valid = busy && !issued && ent.tag1 == tag_none && ent.tag2 == tag_none;
    assign exec_entry = ent;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            issued <= 1'b0;
        end else if (alloc) begin
            busy   <= 1'b1;
            issued <= 1'b0;
        end else begin
            if (exec_valid && exec_ready) begin
                issued <= 1'b1;
            end
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent <= alloc_entry;
        end else if (busy && cdb.valid) begin
            if (ent.tag1 != tag_none && ent.tag1 == cdb.tag) begin
                ent.tag1 <= tag_none;
                ent.val1 <= cdb.data;  // Base address
            end
            if (ent.tag2 != tag_none && ent.tag2 == cdb.tag) begin
                ent.tag2 <= tag_none;
                ent.val2 <= cdb.data;  // Store data
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) alloc |-> !busy)
        else $error("rs_ls: allocated while busy");

    assert property (@(posedge clk) disable iff (rst)
        store_done |-> busy && issued && ent.op == op_store)
        else $error("rs_ls: store_done without a store in flight");

    assert property (@(posedge clk) disable iff (rst)
        cdb_grant |-> busy && issued && ent.op == op_load)
        else $error("rs_ls: grant without a load in flight");

endmodule

// ==== sim/tb_tomasulo.sv ====
`timescale 1ns/10ps

module tb_tomasulo
    import tomasulo_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     issue_valid;
    issue_t   issue;
    logic     issue_ready;
    regaddr_t rd_addr;
    word_t    rd_data;
    tag_t     rd_tag;
    cdb_t     cdb;

    word_t      model_regs [num_regs];
    word_t      model_mem [mem_words];
    word_t      exp_data [4];  // Expected broadcast per station tag
    logic [3:0] exp_pending;
    logic [1:0] alu_busy;      // Mirror of the two ALU station busy flags

    tomasulo_core tomasulo_core_i (
        .clk, .rst, .issue_valid, .issue, .issue_ready,
        .rd_addr, .rd_data, .rd_tag, .cdb
    );

    always #2 clk = ~clk;

    task automatic abort(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            abort($sformatf("FAIL at %0t: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    function automatic issue_t rand_alu();
        issue_t t;
        t.op   = op_e'($urandom_range(0, 4));
        t.dest = regaddr_t'($urandom_range(0, 7));
        t.src1 = regaddr_t'($urandom_range(0, 7));
        t.src2 = regaddr_t'($urandom_range(0, 7));
        t.imm  = $urandom();
        return t;
    endfunction

    function automatic issue_t rand_mem();
        issue_t t;
        t      = rand_alu();
        t.op   = ($urandom_range(0, 1) == 0) ? op_load : op_store;
        t.imm  = $urandom_range(0, 15);
        return t;
    endfunction

    // In-order execution of one accepted instruction
    task automatic run_model(input issue_t t, input tag_t st);
        word_t    a;
        word_t    b;
        word_t    r;
        memaddr_t ma;
        a  = model_regs[t.src1];
        b  = model_regs[t.src2];
        ma = memaddr_t'(a + t.imm);
        case (t.op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_xor:  r = a ^ b;
            op_addi: r = a + t.imm;
            op_load: r = model_mem[ma];
            default: r = '0;
        endcase
        if (t.op == op_store) begin
            model_mem[ma] = b;  // No broadcast for a store
        end else begin
            model_regs[t.dest] = r;
            exp_data[st]       = r;
            exp_pending[st]    = 1'b1;
        end
    endtask

    // One clock cycle that samples at the falling edge and drives after the rising edge
    task automatic step(output bit accepted);
        tag_t st;
        @(negedge clk);
        accepted = issue_valid && issue_ready;
        st       = tag_ls;
        if (cdb.valid) begin
            if (cdb.tag == tag_none || !exp_pending[cdb.tag]) begin
                abort($sformatf("Unexpected CDB broadcast with tag %0d at %0t", cdb.tag, $time));
            end else begin
                check(cdb.data, exp_data[cdb.tag], $sformatf("cdb.data tag %0d", cdb.tag));
                exp_pending[cdb.tag] = 1'b0;
            end
        end
        if (issue_valid && !(issue.op inside {op_load, op_store})) begin
            check(word_t'(issue_ready), word_t'(!(&alu_busy)), "issue_ready");
            st = alu_busy[0] ? tag_alu1 : tag_alu0;  // alu0 first
        end
        if (accepted) begin
            if (exp_pending[st]) begin
                abort("A station took a new instruction before its result was broadcast");
            end else begin
                run_model(issue, st);
            end
        end
        if (cdb.valid && cdb.tag != tag_ls) begin
            alu_busy[cdb.tag == tag_alu1] = 1'b0;
        end
        if (accepted && st != tag_ls) begin
            alu_busy[st == tag_alu1] = 1'b1;
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic send(input issue_t t);
        int n;
        bit acc;
        issue       = t;
        issue_valid = 1'b1;
        n           = 0;
        acc         = 1'b0;
        while (!acc && n < 200) begin
            step(acc);
            n++;
        end
        if (!acc) begin
            abort("Timeout: an instruction was not accepted within 200 cycles");
        end
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        bit acc;
        bit ls_free;
        n = 0;
        while (exp_pending != '0 && n < 500) begin
            step(acc);
            n++;
        end
        if (exp_pending != '0) begin
            abort("Timeout: CDB results still outstanding after 500 cycles");
        end
        issue.op = op_load;  // Ready for a load means the load/store station is free
        n        = 0;
        ls_free  = 1'b0;
        while (!ls_free && n < 50) begin
            step(acc);
            ls_free = issue_ready;
            n++;
        end
        if (!ls_free) begin
            abort("Timeout: load/store station still busy 50 cycles after the drain");
        end
        issue.op = op_add;
    endtask

    task automatic read_regs();
        for (int i = 0; i < num_regs; i++) begin
            rd_addr = regaddr_t'(i);
            @(negedge clk);
            check(rd_data, model_regs[i], $sformatf("rd_data r%0d", i));
            check(word_t'(rd_tag), word_t'(tag_none), $sformatf("rd_tag r%0d", i));
            check(word_t'(cdb.valid), 32'd0, "cdb.valid");
            @(posedge clk);
            #0.5;
        end
    endtask

    initial begin
        bit     acc;
        issue_t t;
        int     prev;
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        rd_addr     = '0;
        exp_pending = '0;
        alu_busy    = '0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            exp_data[i] = '0;
        end
        void'($urandom(66));
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;

        @(negedge clk);
        check(word_t'(issue_ready), 32'd1, "issue_ready");
        check(word_t'(cdb.valid), 32'd0, "cdb.valid");
        @(posedge clk);
        #0.5;
        read_regs();

        for (int i = 0; i < 300; i++) begin
            send(rand_alu());
        end
        drain();
        read_regs();

        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 2) == 0) begin
                send(rand_mem());
            end else begin
                send(rand_alu());
            end
        end
        drain();
        read_regs();

        // Load every memory word once
        for (int a = 0; a < mem_words; a++) begin
            t     = rand_mem();
            t.op  = op_load;
            t.imm = word_t'(a) - model_regs[t.src1];
            send(t);
        end
        drain();
        read_regs();

        // Back to back chains where every other link renames the register it reads
        for (int c = 0; c < 8; c++) begin
            prev = $urandom_range(0, 7);
            for (int k = 0; k < 12; k++) begin
                t      = rand_alu();
                t.src1 = regaddr_t'(prev);
                if (k % 2 == 1) begin
                    t.dest = t.src1;
                end
                prev = t.dest;
                send(t);
            end
        end
        drain();
        read_regs();

        for (int i = 0; i < 20; i++) begin
            step(acc);
        end
        @(negedge clk);
        check(word_t'(issue_ready), 32'd1, "issue_ready");
        @(posedge clk);
        #0.5;
        read_regs();

        $display("TESTS PASSED");
        $finish;
    end

endmodule
